/* list.f */
logic/rom_bus_pkg.sv
logic/snes_timing_pkg.sv
logic/snes_sync.sv
logic/rom_req_slot.sv
logic/rom_arbiter.sv
logic/rom_bus_mux.sv
logic/rom_ctrl_top.sv
tb/rom_ctrl_chk.sv
tb/rom_ctrl_checker.sv
tb/rom_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ROM bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rom_ctrl_tb -o rom_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/rom_ctrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
exit 1

/* tb/rom_ctrl_tb.sv */
`timescale 1ns/1ps

module rom_ctrl_tb
  import rom_bus_pkg::*;
();

  localparam int CYC_LEN    = 7;
  localparam int N_ACCESS   = 48;  // MCU, coprocessor and console accesses
  localparam int WORST_CLKS = 40;  // Free-slot wait plus one full access
  localparam int LIMIT_NS   = (N_ACCESS * WORST_CLKS + 400) * 10;

  logic                  CLK2 = 1'b0;
  logic                  rst_n;
  rom_addr_t             snes_addr;
  logic                  snes_read_n;
  logic                  snes_write_n;
  logic                  snes_cpu_clk;
  byte_t                 snes_din;
  byte_t                 snes_dout;
  logic                  rom_hit;
  logic                  is_writable;
  logic                  mcu_rrq;
  logic                  mcu_wrq;
  rom_addr_t             mcu_addr;
  byte_t                 mcu_wdata;
  logic                  mcu_rdy;
  byte_t                 mcu_rdata;
  logic                  cx4_active;
  logic                  cx4_rrq;
  rom_addr_t             cx4_addr;
  logic                  cx4_rdy;
  byte_t                 cx4_rdata;
  logic [ROM_ADDR_W-2:0] rom_addr;
  logic                  rom_bhe;
  logic                  rom_ble;
  logic                  rom_we;
  rom_word_t             rom_din;
  rom_word_t             rom_dout;
  logic                  rom_dout_en;

  rom_word_t   mem [0:127];  // PSRAM model, 256 bytes
  logic [15:0] lfsr;
  logic        cpu_run;
  logic [2:0]  cpu_div;
  int          test_id;
  logic        test_end;
  int          errors;
  int          checks;

  always #5 CLK2 = ~CLK2;

  rom_ctrl_top #(.rom_cycle_len(CYC_LEN), .dead_timeout(64)) dut0 (.*);

  rom_ctrl_checker #(.rom_cycle_len(CYC_LEN)) u_checker (.*);

  ////////////////////////////////////////////////////////////
  // PSRAM model and console clock
  ////////////////////////////////////////////////////////////

  assign rom_din = mem[rom_addr[6:0]];

  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_bhe) mem[rom_addr[6:0]][15:8] <= rom_dout[15:8];
      if (!rom_ble) mem[rom_addr[6:0]][7:0] <= rom_dout[7:0];
    end
  end

  always @(posedge CLK2) begin
    if (cpu_run) begin
      if (cpu_div == 3'd5) begin  // Six clocks per phase
        cpu_div      <= 3'd0;
        snes_cpu_clk <= !snes_cpu_clk;
      end else begin
        cpu_div <= cpu_div + 3'd1;
      end
    end
  end

  // Same fill rule as the shadow memory
  function automatic byte_t fill_byte(input int a);
    return byte_t'(a * 29 + (a >> 3) + 60);
  endfunction

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic mcu_issue(input logic wr, input rom_addr_t a, input byte_t d);
    @(posedge CLK2);
    mcu_addr  <= a;
    mcu_wdata <= d;
    mcu_wrq   <= wr;
    mcu_rrq   <= !wr;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
  endtask

  task automatic mcu_wait();
    @(negedge CLK2);
    while (!mcu_rdy) @(negedge CLK2);
  endtask

  task automatic mcu_access(input logic wr, input rom_addr_t a, input byte_t d);
    mcu_issue(wr, a, d);
    mcu_wait();
  endtask

  task automatic cx4_read(input rom_addr_t a);
    @(posedge CLK2);
    cx4_addr <= a;
    cx4_rrq  <= 1'b1;
    @(posedge CLK2);
    cx4_rrq <= 1'b0;
    @(negedge CLK2);
    while (!cx4_rdy) @(negedge CLK2);
  endtask

  task automatic console_read(input rom_addr_t a);
    @(posedge CLK2);
    snes_addr   <= a;
    rom_hit     <= 1'b1;
    snes_read_n <= 1'b0;
    repeat (3) @(posedge CLK2);
    snes_read_n <= 1'b1;
    rom_hit     <= 1'b0;
  endtask

  task automatic console_write(input rom_addr_t a, input byte_t d);
    @(posedge CLK2);
    snes_addr    <= a;
    snes_din     <= d;
    rom_hit      <= 1'b1;
    is_writable  <= 1'b1;
    snes_write_n <= 1'b0;
    repeat (14) @(posedge CLK2);  // Spans a high CPU clock phase
    snes_write_n <= 1'b1;
    rom_hit      <= 1'b0;
    is_writable  <= 1'b0;
  endtask

  task automatic finish_test();
    @(posedge CLK2);
    test_end <= 1'b1;
    @(posedge CLK2);
    test_end <= 1'b0;
  endtask

  task automatic mcu_round_trips(input int n);
    logic [31:0] r;
    rom_addr_t   a;
    byte_t       d;
    for (int i = 0; i < n; i++) begin
      rand_bits(7, r);
      a = rom_addr_t'({r[6:0], i[0]});  // Alternate even and odd bytes
      rand_bits(8, r);
      d = r[7:0];
      mcu_access(1'b1, a, d);
      mcu_access(1'b0, a, 8'h00);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    rom_addr_t   a;
    lfsr         = 16'd31904;
    rst_n        = 1'b0;
    snes_addr    = '0;
    snes_read_n  = 1'b1;
    snes_write_n = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_din     = '0;
    rom_hit      = 1'b0;
    is_writable  = 1'b0;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = '0;
    mcu_wdata    = '0;
    cx4_active   = 1'b0;
    cx4_rrq      = 1'b0;
    cx4_addr     = '0;
    cpu_run      = 1'b0;
    cpu_div      = 3'd0;
    test_id      = 1;
    test_end     = 1'b0;
    for (int i = 0; i < 128; i++) mem[i] = {fill_byte(2 * i), fill_byte(2 * i + 1)};
    repeat (4) @(posedge CLK2);
    rst_n <= 1'b1;
    repeat (3) @(posedge CLK2);
    finish_test();

    test_id <= 2;  // Console dead
    mcu_round_trips(8);
    finish_test();

    test_id <= 3;
    cpu_run <= 1'b1;
    repeat (30) @(posedge CLK2);  // Let the dead flag clear
    mcu_round_trips(8);
    finish_test();

    test_id    <= 4;
    cx4_active <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      rand_bits(8, r);
      cx4_read(rom_addr_t'(r[7:0]));
    end
    rand_bits(8, r);
    mcu_issue(1'b0, rom_addr_t'(r[7:0]), 8'h00);
    repeat (30) @(posedge CLK2);  // MCU has to sit out the coprocessor
    cx4_active <= 1'b0;
    mcu_wait();
    finish_test();

    test_id <= 5;
    for (int i = 0; i < 4; i++) begin
      rand_bits(8, r);
      console_read(rom_addr_t'(r[7:0]));
    end
    rand_bits(8, r);
    a = rom_addr_t'(r[7:0]);
    rand_bits(8, r);
    console_write(a, r[7:0]);
    console_read(a);
    finish_test();

    repeat (5) @(posedge CLK2);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    $display("Timeout, the run did not finish within %0d ns", LIMIT_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* tb/rom_ctrl_checker.sv */
`timescale 1ns/1ps

module rom_ctrl_checker
  import rom_bus_pkg::*;
#(
  parameter int rom_cycle_len = 7
) (
  input  logic      CLK2,
  input  logic      rst_n,
  input  int        test_id,
  input  logic      test_end,
  input  logic      mcu_rrq,
  input  logic      mcu_wrq,
  input  rom_addr_t mcu_addr,
  input  byte_t     mcu_wdata,
  input  logic      mcu_rdy,
  input  byte_t     mcu_rdata,
  input  logic      cx4_active,
  input  logic      cx4_rrq,
  input  rom_addr_t cx4_addr,
  input  logic      cx4_rdy,
  input  byte_t     cx4_rdata,
  input  rom_addr_t snes_addr,
  input  logic      snes_read_n,
  input  logic      snes_write_n,
  input  logic      snes_cpu_clk,
  input  byte_t     snes_din,
  input  byte_t     snes_dout,
  input  logic      rom_hit,
  input  logic      is_writable,
  input  logic      rom_we,
  input  logic      rom_dout_en,
  output int        errors,
  output int        checks
);

  byte_t       shadow [0:255];
  rom_addr_t   mcu_addr_q;
  rom_addr_t   cx4_addr_q;
  logic        mcu_rd_q;
  logic        mcu_rdy_q;
  logic        cx4_rdy_q;
  int          mcu_lat;
  int          cx4_lat;
  int          errs_at_start;
  logic        cpu_q;
  logic [31:0] cpu_edges;  // Bit n set when a console clock edge was seen n clocks ago

  function automatic byte_t fill_byte(input int a);
    return byte_t'(a * 29 + (a >> 3) + 60);
  endfunction

  // Expected byte at a ROM address
  function automatic byte_t ref_byte(input rom_addr_t a);
    return shadow[a[7:0]];
  endfunction

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  initial begin
    errors        = 0;
    checks        = 0;
    errs_at_start = 0;
    mcu_rd_q      = 1'b0;
    mcu_rdy_q     = 1'b1;
    cx4_rdy_q     = 1'b1;
    mcu_lat       = 0;
    cx4_lat       = 0;
    cpu_q         = 1'b0;
    cpu_edges     = '0;
    for (int a = 0; a < 256; a++) shadow[a] = fill_byte(a);
  end

  // Request capture and shadow updates
  always @(posedge CLK2) begin
    if (rst_n) begin
      mcu_lat++;
      cx4_lat++;
      cpu_edges = {cpu_edges[30:0], snes_cpu_clk != cpu_q};
      cpu_q     = snes_cpu_clk;
      if (mcu_rrq || mcu_wrq) begin
        mcu_addr_q = mcu_addr;
        mcu_rd_q   = mcu_rrq;
        mcu_lat    = 0;
      end
      if (mcu_wrq) shadow[mcu_addr[7:0]] = mcu_wdata;
      if (cx4_rrq && cx4_active) begin
        cx4_addr_q = cx4_addr;
        cx4_lat    = 0;
      end
      if (rom_hit && is_writable && !snes_write_n) begin
        shadow[snes_addr[7:0]] = snes_din;  // Console write to writable ROM
      end
      if (test_end) begin
        $display("test %0d finished, %0d errors", test_id, errors - errs_at_start);
        errs_at_start = errors;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparisons on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge CLK2) begin
    if (rst_n) begin
      if (test_id == 1) begin
        checks++;
        if (!(mcu_rdy && cx4_rdy && rom_we && !rom_dout_en)) begin
          errors++;
          $display("error %0t: outputs after reset are not idle", $time);
        end
      end
      if (mcu_rdy && !mcu_rdy_q) begin
        if (mcu_lat < rom_cycle_len + 3) begin
          errors++;
          $display("MCU access at %0t ns ended after %0d clocks, too soon", $time, mcu_lat);
        end
        if (cx4_active) begin
          errors++;
          $display("MCU access at %0t ns ended while the coprocessor was active", $time);
        end
        // Slot pulse trails the console edge by four clocks, then a full access
        if (cpu_edges != '0 && !cpu_edges[rom_cycle_len + 7]) begin
          errors++;
          $display("MCU access at %0t ns did not start on a console free slot", $time);
        end
        if (mcu_rd_q) begin
          check_byte($sformatf("mcu read %h", mcu_addr_q), mcu_rdata, ref_byte(mcu_addr_q));
        end
      end
      if (cx4_rdy && !cx4_rdy_q) begin
        check_byte($sformatf("cx4 read %h", cx4_addr_q), cx4_rdata, ref_byte(cx4_addr_q));
      end
      if (!snes_read_n && rom_hit) begin
        check_byte($sformatf("console read %h", snes_addr), snes_dout, ref_byte(snes_addr));
      end
      mcu_rdy_q = mcu_rdy;
      cx4_rdy_q = cx4_rdy;
    end
  end

endmodule

/* tb/rom_ctrl_chk.sv */
`timescale 1ns/1ps

module rom_ctrl_chk (
  input logic CLK2,
  input logic rst_n,
  input logic rom_we,
  input logic rom_bhe,
  input logic rom_ble,
  input logic rom_dout_en,
  input logic mcu_rdy,
  input logic cx4_rdy,
  input logic mcu_rd_grant,
  input logic mcu_wr_grant,
  input logic cx4_grant,
  input logic mcu_rrq,
  input logic mcu_wrq,
  input logic cx4_rrq,
  input logic cx4_active
);

  // One lane and driven data on every write
  lane_one_hot: assert property (@(posedge CLK2) disable iff (!rst_n)
    !rom_we |-> (rom_bhe != rom_ble) && rom_dout_en)
    else $error("write without exactly one byte lane or without driven data");

  no_idle_grant: assert property (@(posedge CLK2) disable iff (!rst_n)
    (mcu_rdy && cx4_rdy) |-> !(mcu_rd_grant || mcu_wr_grant || cx4_grant))
    else $error("grant while no request is pending");

  mcu_rdy_cause: assert property (@(posedge CLK2) disable iff (!rst_n)
    $fell(mcu_rdy) |-> $past(mcu_rrq || mcu_wrq))
    else $error("mcu_rdy fell without a request");

  cx4_rdy_cause: assert property (@(posedge CLK2) disable iff (!rst_n)
    $fell(cx4_rdy) |-> $past(cx4_rrq && cx4_active))
    else $error("cx4_rdy fell without a request");

endmodule

bind rom_ctrl_top rom_ctrl_chk chk_b (
  .CLK2(CLK2), .rst_n(rst_n), .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble),
  .rom_dout_en(rom_dout_en),
  .mcu_rdy(mcu_rdy), .cx4_rdy(cx4_rdy), .mcu_rd_grant(mcu_rd_grant),
  .mcu_wr_grant(mcu_wr_grant), .cx4_grant(cx4_grant), .mcu_rrq(mcu_rrq),
  .mcu_wrq(mcu_wrq), .cx4_rrq(cx4_rrq), .cx4_active(cx4_active)
);

/* logic/rom_ctrl_top.sv */
`timescale 1ns/1ps

module rom_ctrl_top
  import rom_bus_pkg::*;
  import snes_timing_pkg::*;
#(
  parameter int rom_cycle_len = DEF_ROM_CYCLE_LEN,
  parameter int dead_timeout  = DEF_DEAD_TIMEOUT
) (
  input  logic                  CLK2,
  input  logic                  rst_n,
  // Console
  input  rom_addr_t             snes_addr,
  input  logic                  snes_read_n,
  input  logic                  snes_write_n,
  input  logic                  snes_cpu_clk,
  input  byte_t                 snes_din,
  output byte_t                 snes_dout,
  input  logic                  rom_hit,
  input  logic                  is_writable,
  // MCU
  input  logic                  mcu_rrq,
  input  logic                  mcu_wrq,
  input  rom_addr_t             mcu_addr,
  input  byte_t                 mcu_wdata,
  output logic                  mcu_rdy,
  output byte_t                 mcu_rdata,
  // Coprocessor
  input  logic                  cx4_active,
  input  logic                  cx4_rrq,
  input  rom_addr_t             cx4_addr,
  output logic                  cx4_rdy,
  output byte_t                 cx4_rdata,
  // PSRAM
  output logic [ROM_ADDR_W-2:0] rom_addr,
  output logic                  rom_bhe,
  output logic                  rom_ble,
  output logic                  rom_we,
  input  rom_word_t             rom_din,
  output rom_word_t             rom_dout,
  output logic                  rom_dout_en
);

  logic     free_slot;
  logic     snes_dead;
  logic     mcu_pending;
  logic     cx4_pending;
  logic     mcu_done;
  logic     cx4_done;
  logic     mcu_rd_grant;
  logic     mcu_wr_grant;
  logic     cx4_grant;
  byte_t    rom_byte;
  mcu_req_t mcu_req_in;
  mcu_req_t mcu_held;
  cx4_req_t cx4_req_in;
  cx4_req_t cx4_held;

  assign mcu_req_in = '{addr: mcu_addr, wr: mcu_wrq, wdata: mcu_wdata};
  assign cx4_req_in = '{addr: cx4_addr};
  assign snes_dout  = rom_byte;  // Valid while snes_read_n is low

  snes_sync #(.dead_timeout(dead_timeout)) u_sync (
    .CLK2(CLK2), .rst_n(rst_n), .snes_cpu_clk(snes_cpu_clk),
    .snes_read_n(snes_read_n), .snes_write_n(snes_write_n), .rom_hit(rom_hit),
    .cycle_start(), .cycle_end(), .wr_end(),
    .free_slot(free_slot), .snes_dead(snes_dead)
  );

  ////////////////////////////////////////////////////////////
  // Request slots
  ////////////////////////////////////////////////////////////

  rom_req_slot #(.payload_t(mcu_req_t)) u_mcu_slot (
    .CLK2(CLK2), .rst_n(rst_n), .req(mcu_rrq || mcu_wrq), .req_data(mcu_req_in),
    .done(mcu_done), .enable(1'b1),
    .pending(mcu_pending), .rdy(mcu_rdy), .held(mcu_held)
  );

  rom_req_slot #(.payload_t(cx4_req_t)) u_cx4_slot (
    .CLK2(CLK2), .rst_n(rst_n), .req(cx4_rrq), .req_data(cx4_req_in),
    .done(cx4_done), .enable(cx4_active),
    .pending(cx4_pending), .rdy(cx4_rdy), .held(cx4_held)
  );

  rom_arbiter #(.rom_cycle_len(rom_cycle_len)) u_arb (
    .CLK2(CLK2), .rst_n(rst_n), .mcu_pending(mcu_pending), .cx4_pending(cx4_pending),
    .cx4_active(cx4_active), .free_slot(free_slot), .snes_dead(snes_dead),
    .snes_cpu_clk(snes_cpu_clk), .mcu_held(mcu_held), .rom_byte(rom_byte),
    .mcu_done(mcu_done), .cx4_done(cx4_done),
    .mcu_rdata(mcu_rdata), .cx4_rdata(cx4_rdata),
    .mcu_rd_grant(mcu_rd_grant), .mcu_wr_grant(mcu_wr_grant), .cx4_grant(cx4_grant)
  );

  rom_bus_mux u_mux (
    .snes_addr(snes_addr), .mcu_addr(mcu_held.addr), .cx4_addr(cx4_held.addr),
    .mcu_rd_grant(mcu_rd_grant), .mcu_wr_grant(mcu_wr_grant), .cx4_grant(cx4_grant),
    .rom_hit(rom_hit), .is_writable(is_writable), .snes_cpu_clk(snes_cpu_clk),
    .snes_write_n(snes_write_n), .snes_din(snes_din), .mcu_wdata(mcu_held.wdata),
    .rom_din(rom_din), .rom_addr(rom_addr), .rom_bhe(rom_bhe), .rom_ble(rom_ble),
    .rom_we(rom_we), .rom_dout(rom_dout), .rom_dout_en(rom_dout_en),
    .rom_byte(rom_byte)
  );

endmodule

/* logic/rom_bus_mux.sv */
`timescale 1ns/1ps

module rom_bus_mux
  import rom_bus_pkg::*;
(
  input  rom_addr_t               snes_addr,  // Already mapped
  input  rom_addr_t               mcu_addr,
  input  rom_addr_t               cx4_addr,
  input  logic                    mcu_rd_grant,
  input  logic                    mcu_wr_grant,
  input  logic                    cx4_grant,
  input  logic                    rom_hit,
  input  logic                    is_writable,
  input  logic                    snes_cpu_clk,
  input  logic                    snes_write_n,
  input  byte_t                   snes_din,
  input  byte_t                   mcu_wdata,
  input  rom_word_t               rom_din,
  output logic [ROM_ADDR_W-2:0]   rom_addr,
  output logic                    rom_bhe,
  output logic                    rom_ble,
  output logic                    rom_we,
  output rom_word_t               rom_dout,
  output logic                    rom_dout_en,
  output byte_t                   rom_byte
);

  rom_addr_t sel_addr;
  logic      lo_lane;  // Odd byte sits in the low half
  byte_t     wr_byte;

  always_comb begin
    if (mcu_rd_grant || mcu_wr_grant) sel_addr = mcu_addr;
    else if (cx4_grant)               sel_addr = cx4_addr;
    else                              sel_addr = snes_addr;
  end

  assign lo_lane  = sel_addr[0];
  assign rom_addr = sel_addr[ROM_ADDR_W-1:1];
  assign rom_bhe  = lo_lane;   // Active low
  assign rom_ble  = !lo_lane;
  assign rom_byte = lo_lane ? rom_din[7:0] : rom_din[15:8];

  ////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////

  assign wr_byte     = mcu_wr_grant ? mcu_wdata : snes_din;
  assign rom_dout    = lo_lane ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_dout_en = mcu_wr_grant || (rom_hit && !snes_write_n);

  always_comb begin
    if (rom_hit && is_writable && snes_cpu_clk) rom_we = snes_write_n;
    else if (mcu_wr_grant)                      rom_we = 1'b0;
    else                                        rom_we = 1'b1;
  end

endmodule

/* logic/rom_arbiter.sv */
`timescale 1ns/1ps

module rom_arbiter
  import rom_bus_pkg::*;
  import snes_timing_pkg::*;
#(
  parameter int rom_cycle_len = DEF_ROM_CYCLE_LEN
) (
  input  logic     CLK2,
  input  logic     rst_n,
  input  logic     mcu_pending,
  input  logic     cx4_pending,
  input  logic     cx4_active,
  input  logic     free_slot,
  input  logic     snes_dead,
  input  logic     snes_cpu_clk,
  input  mcu_req_t mcu_held,
  input  byte_t    rom_byte,
  output logic     mcu_done,
  output logic     cx4_done,
  output byte_t    mcu_rdata,
  output byte_t    cx4_rdata,
  output logic     mcu_rd_grant,
  output logic     mcu_wr_grant,
  output logic     cx4_grant
);

  localparam int DLY_W = (rom_cycle_len > 0) ? $clog2(rom_cycle_len + 1) : 1;

  arb_state_t       state;
  logic [DLY_W-1:0] delay;
  logic             mcu_go;
  logic             restart;

  // MCU may only use a free bus slot unless the console is gone
  assign mcu_go = mcu_pending && (free_slot || snes_dead);

  // Console woke up mid-access, slot stays pending so the cycle reruns
  assign restart = snes_dead && snes_cpu_clk
                   && (state == ST_MCU_RD || state == ST_MCU_WR);

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (restart) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cx4_active) begin  // Coprocessor owns the bus, MCU waits
            if (cx4_pending) begin
              state <= ST_CX4_RD;
              delay <= DLY_W'(rom_cycle_len);
            end
          end else if (mcu_go) begin
            state <= mcu_held.wr ? ST_MCU_WR : ST_MCU_RD;
            delay <= DLY_W'(rom_cycle_len);
          end
        end
        ST_MCU_RD: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_MCU_RD_END;
        end
        ST_MCU_WR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_MCU_WR_END;
        end
        ST_CX4_RD: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_CX4_RD_END;
        end
        default: state <= ST_IDLE;  // End states last one clock
      endcase
    end
  end

  // Last sample of the cycle is the one that sticks
  always_ff @(posedge CLK2) begin
    if (state == ST_MCU_RD) mcu_rdata <= rom_byte;
    if (state == ST_CX4_RD) cx4_rdata <= rom_byte;
  end

  assign mcu_done     = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);
  assign cx4_done     = (state == ST_CX4_RD_END);
  assign mcu_rd_grant = (state == ST_MCU_RD);
  assign mcu_wr_grant = (state == ST_MCU_WR);
  assign cx4_grant    = (state == ST_CX4_RD);

endmodule

/* logic/rom_req_slot.sv */
`timescale 1ns/1ps

module rom_req_slot #(
  parameter type payload_t = logic
) (
  input  logic     CLK2,
  input  logic     rst_n,
  input  logic     req,       // One-cycle request pulse
  input  payload_t req_data,
  input  logic     done,      // Arbiter end state
  input  logic     enable,
  output logic     pending,
  output logic     rdy,
  output payload_t held
);

  // Pending and ready move together
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
      rdy     <= 1'b1;
    end else if (enable) begin
      if (req) begin
        pending <= 1'b1;
        rdy     <= 1'b0;
      end else if (done) begin
        pending <= 1'b0;
        rdy     <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK2) begin
    if (enable && req) begin
      held <= req_data;  // Kept until the next request
    end
  end

endmodule

/* logic/snes_sync.sv */
`timescale 1ns/1ps

module snes_sync
  import snes_timing_pkg::*;
#(
  parameter int dead_timeout = DEF_DEAD_TIMEOUT
) (
  input  logic CLK2,
  input  logic rst_n,
  input  logic snes_cpu_clk,
  input  logic snes_read_n,
  input  logic snes_write_n,
  input  logic rom_hit,
  output logic cycle_start,
  output logic cycle_end,
  output logic wr_end,
  output logic free_slot,
  output logic snes_dead
);

  logic [STROBE_HIST-1:0] clk_hist;
  logic [STROBE_HIST-1:0] rd_hist;
  logic [STROBE_HIST-1:0] wr_hist;
  logic                   rom_busy;
  dead_cnt_t              dead_cnt;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      clk_hist <= '0;
      rd_hist  <= '1;  // Strobes idle high
      wr_hist  <= '1;
    end else begin
      clk_hist <= {clk_hist[STROBE_HIST-2:0], snes_cpu_clk};
      rd_hist  <= {rd_hist[STROBE_HIST-2:0], snes_read_n};
      wr_hist  <= {wr_hist[STROBE_HIST-2:0], snes_write_n};
    end
  end

  assign cycle_start = (clk_hist[EDGE_POS +: 4] == EDGE_RISE);
  assign cycle_end   = (clk_hist[EDGE_POS +: 4] == EDGE_FALL);
  assign wr_end      = (wr_hist[EDGE_POS +: 4] == EDGE_RISE);  // Write strobe released

  // Console owns the PSRAM only on a hit with a strobe active
  assign rom_busy  = rom_hit && !(rd_hist[0] && wr_hist[0]);
  assign free_slot = cycle_end || (cycle_start && !rom_busy);

  ////////////////////////////////////////////////////////////
  // Dead console detection
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (clk_hist[0]) begin
      dead_cnt <= '0;
    end else if (dead_cnt != '1) begin
      dead_cnt <= dead_cnt + 1'b1;  // Saturates
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      snes_dead <= 1'b1;
    end else if (dead_cnt > dead_cnt_t'(dead_timeout)) begin
      snes_dead <= 1'b1;
    end else if (clk_hist[0]) begin
      snes_dead <= 1'b0;
    end
  end

endmodule

/* logic/snes_timing_pkg.sv */
package snes_timing_pkg;

  localparam int STROBE_HIST = 8;  // Samples kept per console strobe

  // Edge window sits in the oldest four samples
  localparam int         EDGE_POS  = 4;
  localparam logic [3:0] EDGE_RISE = 4'b0001;
  localparam logic [3:0] EDGE_FALL = 4'b1110;

  localparam int DEF_ROM_CYCLE_LEN = 7;
  localparam int DEF_DEAD_TIMEOUT  = 88000;  // About 1 ms of CLK2

  typedef logic [17:0] dead_cnt_t;

endpackage

/* logic/rom_bus_pkg.sv */
package rom_bus_pkg;

  localparam int ROM_ADDR_W = 24;  // Byte address into PSRAM

  typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [15:0]           rom_word_t;  // One PSRAM word
  typedef logic [7:0]            byte_t;

  // MCU request as latched in its slot
  typedef struct packed {
    rom_addr_t addr;
    logic      wr;     // Set for a write
    byte_t     wdata;
  } mcu_req_t;

  typedef struct packed {
    rom_addr_t addr;
  } cx4_req_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MCU_RD,
    ST_MCU_RD_END,
    ST_MCU_WR,
    ST_MCU_WR_END,
    ST_CX4_RD,
    ST_CX4_RD_END
  } arb_state_t;

endpackage
